//--- lpddr_apb_regs.f
+incdir+include
hdl/apb_bus_pkg.sv
hdl/lpddr_reg_pkg.sv
hdl/reg_access_if.sv
hdl/apb_access_decode.sv
hdl/mode_reg_bank.sv
hdl/timing_reg_bank.sv
hdl/read_data_mux.sv
hdl/lpddr_apb_regs.sv
verif/lpddr_apb_regs_checker.sv
verif/tb_lpddr_apb_regs.sv

//--- verif/lpddr_apb_input.txt
// columns: op address data strobe expected, all hex
// op 0 write, 1 read and compare, 2 write with penable low, 3 compare timer1 outputs
// reset values
1 0000 00000000 0 00000000
1 0004 00000000 0 00000000
1 0030 00000000 0 00000000
1 0034 00000000 0 00000000
1 0038 00000000 0 00000000
1 004C 00000000 0 00000000
1 0050 00000000 0 00000000
1 005C 00000000 0 00000000
3 0000 00000000 0 00000000
// full strobe writes, reserved bits read zero
0 0000 FFFFFFFF F 00000000
1 0000 00000000 0 8703FFFF
0 0004 FFFFFFFF F 00000000
1 0004 00000000 0 FFFF0701
0 0030 FFFFFFFF F 00000000
1 0030 00000000 0 3FFFFFFF
3 0000 00000000 0 3FFFFFFF
0 0034 12345678 F 00000000
1 0034 00000000 0 12345678
0 0038 FFFFFFFF F 00000000
1 0038 00000000 0 001FFFFF
0 004C A5A5C3C3 F 00000000
1 004C 00000000 0 A5A5C3C3
0 0050 0BADF00D F 00000000
1 0050 00000000 0 0BADF00D
0 005C FFFFFFFF F 00000000
1 005C 00000000 0 00000001
// partial strobes
0 0000 11223344 5 00000000
1 0000 00000000 0 8702FF44
0 0004 00000000 8 00000000
1 0004 00000000 0 00FF0701
0 0030 00000000 C 00000000
1 0030 00000000 0 0000FFFF
3 0000 00000000 0 0000FFFF
0 0030 12345678 1 00000000
3 0000 00000000 0 0000FF78
0 0034 AABBCCDD 2 00000000
1 0034 00000000 0 1234CC78
0 0038 00ABCDEF 6 00000000
1 0038 00000000 0 000BCDFF
0 004C 11223344 9 00000000
1 004C 00000000 0 11A5C344
// ignored writes and unmapped addresses
2 0030 00000000 F 00000000
1 0030 00000000 0 0000FF78
3 0000 00000000 0 0000FF78
2 0000 00000000 F 00000000
1 0000 00000000 0 8702FF44
0 0040 FFFFFFFF F 00000000
1 0040 00000000 0 00000000
0 8030 00000000 F 00000000
1 0030 00000000 0 0000FF78
1 0100 00000000 0 00000000
1 0036 00000000 0 1234CC78

//--- verif/tb_lpddr_apb_regs.sv
////////////////////////////////////////
// LPDDR APB register testbench
////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

`include "lpddr_regs_config.svh"

module tb_lpddr_apb_regs;
	import apb_bus_pkg::*;
	import lpddr_reg_pkg::*;

	localparam int MAX_TESTS  = 64;
	localparam int REC_WORDS  = 5;     // op, address, data, strobe, expected
	localparam int RST_CYCLES = 10;
	localparam int MARGIN     = 20;

	localparam logic [3:0] OP_WRITE  = 4'h0;
	localparam logic [3:0] OP_READ   = 4'h1;
	localparam logic [3:0] OP_NOENA  = 4'h2;    // write that never enters the access phase
	localparam logic [3:0] OP_TIM1   = 4'h3;

	logic       pclk;
	logic       prst_n;
	apb_addr_t  paddr;
	logic       psel;
	logic       penable;
	logic       pwrite;
	apb_data_t  pwdata;
	apb_strb_t  pstrb;
	logic       pready;
	apb_data_t  prdata;
	logic       pslverr;
	logic [6:0] t_act2pre;
	logic [4:0] t_rd2pre;
	logic [5:0] t_act2rw;
	logic [5:0] t_pre_pb2any;
	logic [5:0] t_pre_ab2any;

	logic [`LPDDR_APB_DW-1:0] stim [0:MAX_TESTS*REC_WORDS-1];

	int n_tests     = 0;
	int cycles      = 0;
	int cycle_limit = 1000;    // replaced once the data file is read
	int errors      = 0;
	int passed      = 0;
	int failed      = 0;

	lpddr_apb_regs u_dut
	(
		.pclk_i         (pclk),
		.prst_ni        (prst_n),
		.paddr_i        (paddr),
		.psel_i         (psel),
		.penable_i      (penable),
		.pwrite_i       (pwrite),
		.pwdata_i       (pwdata),
		.pstrb_i        (pstrb),
		.pready_o       (pready),
		.prdata_o       (prdata),
		.pslverr_o      (pslverr),
		.t_act2pre_o    (t_act2pre),
		.t_rd2pre_o     (t_rd2pre),
		.t_act2rw_o     (t_act2rw),
		.t_pre_pb2any_o (t_pre_pb2any),
		.t_pre_ab2any_o (t_pre_ab2any)
	);

	always #20 pclk = ~pclk;    // 40 ns period

	always @(posedge pclk)
	begin
		cycles = cycles + 1;
		if (cycles >= cycle_limit)
		begin
			$display("timeout after %0d cycles, the test sequence did not complete", cycles);
			$display("Verification failed");
			$finish;
		end
	end

	////////////////////////////////////////
	// compare tasks
	////////////////////////////////////////
	task automatic check_data(input string name, input apb_data_t exp, input apb_data_t act);
		if (act !== exp)
		begin
			$display("** Error %s: expected 0x%08h, actual 0x%08h", name, exp, act);
			errors++;
		end
	endtask

	task automatic check_tim1(input string name, input tim1_fields_t exp,
		input tim1_fields_t act);
		if (act !== exp)
		begin
			$display("** Error %s: expected 0x%08h, actual 0x%08h", name, exp, act);
			errors++;
		end
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		if (act !== exp)
		begin
			$display("** Error %s: expected %b, actual %b", name, exp, act);
			errors++;
		end
	endtask

	// timer1 ports gathered into the field layout
	function automatic tim1_fields_t tim1_ports();
		tim1_fields_t f;
		f.rsvd       = '0;
		f.pre_ab2any = t_pre_ab2any;
		f.pre_pb2any = t_pre_pb2any;
		f.act2rw     = t_act2rw;
		f.rd2pre     = t_rd2pre;
		f.act2pre    = t_act2pre;
		return f;
	endfunction

	////////////////////////////////////////
	// bus transfers
	////////////////////////////////////////
	// setup phase, then access phase until ready, then idle
	task automatic apb_transfer(input string name, input logic wr, input logic ena,
		input apb_addr_t addr, input apb_data_t data, input apb_strb_t strb,
		input logic cmp_rd, input apb_data_t exp);
		@(posedge pclk);
		psel    <= 1'b1;
		penable <= 1'b0;
		pwrite  <= wr;
		paddr   <= addr;
		pwdata  <= data;
		pstrb   <= strb;
		@(negedge pclk);
		check_bit({name, " setup pready"}, 1'b1, pready);
		@(posedge pclk);
		penable <= ena;
		@(negedge pclk);
		while (pready !== 1'b1)
			@(negedge pclk);    // watchdog ends a stuck transfer
		check_bit({name, " pslverr"}, 1'b0, pslverr);
		if (cmp_rd)
			check_data(name, exp, prdata);
		@(posedge pclk);
		psel    <= 1'b0;
		penable <= 1'b0;
		pwrite  <= 1'b0;
		@(negedge pclk);
		check_bit({name, " idle pready"}, 1'b0, pready);
		check_bit({name, " idle pslverr"}, 1'b0, pslverr);
	endtask

	task automatic run_test(input int idx);
		logic [3:0] op;
		apb_addr_t  addr;
		apb_data_t  data;
		apb_strb_t  strb;
		apb_data_t  exp;
		string      name;
		int         err_before;
		op         = stim[idx*REC_WORDS][3:0];
		addr       = stim[idx*REC_WORDS+1][`LPDDR_APB_AW-1:0];
		data       = stim[idx*REC_WORDS+2];
		strb       = stim[idx*REC_WORDS+3][`LPDDR_APB_SW-1:0];
		exp        = stim[idx*REC_WORDS+4];
		err_before = errors;
		case (op)
			OP_WRITE:
			begin
				name = $sformatf("test %0d write 0x%04h", idx, addr);
				apb_transfer(name, 1'b1, 1'b1, addr, data, strb, 1'b0, '0);
			end
			OP_READ:
			begin
				name = $sformatf("test %0d read 0x%04h", idx, addr);
				apb_transfer(name, 1'b0, 1'b1, addr, '0, '0, 1'b1, exp);
			end
			OP_NOENA:
			begin
				name = $sformatf("test %0d write without penable 0x%04h", idx, addr);
				apb_transfer(name, 1'b1, 1'b0, addr, data, strb, 1'b0, '0);
			end
			OP_TIM1:
			begin
				name = $sformatf("test %0d timer1 outputs", idx);
				@(negedge pclk);
				check_tim1(name, tim1_fields_t'(exp), tim1_ports());
			end
			default:
			begin
				name = $sformatf("test %0d", idx);
				$display("%s has an unknown operation code %0h", name, op);
				errors++;
			end
		endcase
		if (errors == err_before)
		begin
			passed++;
			$display("pass  %s", name);
		end
		else
		begin
			failed++;
			$display("FAIL  %s", name);
		end
	endtask

	////////////////////////////////////////
	// main sequence
	////////////////////////////////////////
	initial
	begin
		pclk    = 1'b0;
		prst_n  = 1'b0;
		paddr   = '0;
		psel    = 1'b0;
		penable = 1'b0;
		pwrite  = 1'b0;
		pwdata  = '0;
		pstrb   = '0;
		$readmemh("verif/lpddr_apb_input.txt", stim);
		while (n_tests < MAX_TESTS && !$isunknown(stim[n_tests*REC_WORDS]))
			n_tests++;
		if (n_tests == 0)
		begin
			$display("no tests could be read from the data file");
			errors++;
		end
		cycle_limit = n_tests * 4 + RST_CYCLES + MARGIN;

		repeat (RST_CYCLES) @(posedge pclk);
		prst_n <= 1'b1;

		for (int i = 0; i < n_tests; i++)
			run_test(i);

		@(negedge pclk);
		$display("tests run %0d, passed %0d, failed %0d, errors %0d, assertion failures %0d",
			n_tests, passed, failed, errors, u_dut.u_checker.fail_count);
		if (errors == 0 && failed == 0 && u_dut.u_checker.fail_count == 0)
			$display("Verification passed");
		else
			$display("Verification failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- verif/lpddr_apb_regs_checker.sv
////////////////////////////////////////
// APB protocol assertions
////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module lpddr_apb_regs_checker
(
	input logic                   pclk_i,
	input logic                   prst_ni,
	input logic                   psel_i,
	input logic                   pwrite_i,
	input logic                   pready_i,
	input logic                   pslverr_i,
	input apb_bus_pkg::apb_data_t prdata_i
);

	int fail_count = 0;    // assertion failures so far

	// no wait states, ready is the select level
	property ready_tracks_sel;
		@(posedge pclk_i) disable iff (!prst_ni)
			pready_i == psel_i;
	endproperty

	property no_slave_error;
		@(posedge pclk_i) disable iff (!prst_ni)
			!pslverr_i;
	endproperty

	// read data only loads on an edge with a read selected
	property rdata_held;
		@(posedge pclk_i) disable iff (!prst_ni)
			!(psel_i && !pwrite_i) |=> $stable(prdata_i);
	endproperty

	a_ready_tracks_sel: assert property (ready_tracks_sel)
		else
		begin
			fail_count++;
			$error("pready differs from psel");
		end

	a_no_slave_error: assert property (no_slave_error)
		else
		begin
			fail_count++;
			$error("pslverr went high");
		end

	a_rdata_held: assert property (rdata_held)
		else
		begin
			fail_count++;
			$error("prdata changed without a read selected");
		end

endmodule

bind lpddr_apb_regs lpddr_apb_regs_checker u_checker
(
	.pclk_i    (pclk_i),
	.prst_ni   (prst_ni),
	.psel_i    (psel_i),
	.pwrite_i  (pwrite_i),
	.pready_i  (pready_o),
	.pslverr_i (pslverr_o),
	.prdata_i  (prdata_o)
);

`default_nettype wire

//--- hdl/lpddr_apb_regs.sv
////////////////////////////////////////
// LPDDR APB register port
////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module lpddr_apb_regs
(
	input  logic                   pclk_i,
	input  logic                   prst_ni,
	input  apb_bus_pkg::apb_addr_t paddr_i,
	input  logic                   psel_i,
	input  logic                   penable_i,
	input  logic                   pwrite_i,
	input  apb_bus_pkg::apb_data_t pwdata_i,
	input  apb_bus_pkg::apb_strb_t pstrb_i,
	output logic                   pready_o,
	output apb_bus_pkg::apb_data_t prdata_o,
	output logic                   pslverr_o,
	output logic [6:0]             t_act2pre_o,
	output logic [4:0]             t_rd2pre_o,
	output logic [5:0]             t_act2rw_o,
	output logic [5:0]             t_pre_pb2any_o,
	output logic [5:0]             t_pre_ab2any_o
);
	import apb_bus_pkg::*;
	import lpddr_reg_pkg::*;

	apb_data_t    mode_rdata;
	apb_data_t    timing_rdata;
	tim1_fields_t tim1;

	reg_access_if u_acc ();

	apb_access_decode u_decode
	(
		.paddr_i   (paddr_i),
		.psel_i    (psel_i),
		.penable_i (penable_i),
		.pwrite_i  (pwrite_i),
		.pwdata_i  (pwdata_i),
		.pstrb_i   (pstrb_i),
		.pready_o  (pready_o),
		.pslverr_o (pslverr_o),
		.acc       (u_acc.decoder)
	);

	mode_reg_bank u_mode
	(
		.pclk_i  (pclk_i),
		.prst_ni (prst_ni),
		.acc     (u_acc.bank),
		.rdata_o (mode_rdata)
	);

	timing_reg_bank u_timing
	(
		.pclk_i  (pclk_i),
		.prst_ni (prst_ni),
		.acc     (u_acc.bank),
		.rdata_o (timing_rdata),
		.tim1_o  (tim1)
	);

	read_data_mux u_rdmux
	(
		.pclk_i         (pclk_i),
		.prst_ni        (prst_ni),
		.acc            (u_acc.bank),
		.mode_rdata_i   (mode_rdata),
		.timing_rdata_i (timing_rdata),
		.prdata_o       (prdata_o)
	);

	// timer1 fields out to the controller
	assign t_act2pre_o    = tim1.act2pre;
	assign t_rd2pre_o     = tim1.rd2pre;
	assign t_act2rw_o     = tim1.act2rw;
	assign t_pre_pb2any_o = tim1.pre_pb2any;
	assign t_pre_ab2any_o = tim1.pre_ab2any;

endmodule

`default_nettype wire

//--- hdl/read_data_mux.sv
////////////////////////////////////////
// APB read data register
////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module read_data_mux
(
	input  logic                   pclk_i,
	input  logic                   prst_ni,
	reg_access_if.bank             acc,
	input  apb_bus_pkg::apb_data_t mode_rdata_i,
	input  apb_bus_pkg::apb_data_t timing_rdata_i,
	output apb_bus_pkg::apb_data_t prdata_o
);
	import apb_bus_pkg::*;
	import lpddr_reg_pkg::*;

	apb_data_t rdata_c;

	// pick the bank that owns the selected register
	always_comb
	begin
		case (acc.sel)
			REG_MR,
			REG_PPR:  rdata_c = mode_rdata_i;
			REG_NONE: rdata_c = '0;                // unmapped reads zero
			default:  rdata_c = timing_rdata_i;
		endcase
	end

	////////////////////////////////////////
	// sampled in the setup phase of a read
	////////////////////////////////////////
	always_ff @(posedge pclk_i or negedge prst_ni)
	begin
		if (!prst_ni)
			prdata_o <= '0;
		else if (acc.rd_en)
			prdata_o <= rdata_c;    // held between reads
	end

endmodule

`default_nettype wire

//--- hdl/timing_reg_bank.sv
////////////////////////////////////////
// Timer registers
////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module timing_reg_bank
(
	input  logic                        pclk_i,
	input  logic                        prst_ni,
	reg_access_if.bank                  acc,
	output apb_bus_pkg::apb_data_t      rdata_o,
	output lpddr_reg_pkg::tim1_fields_t tim1_o
);
	import apb_bus_pkg::*;
	import lpddr_reg_pkg::*;

	// defined bits of the partly reserved words
	localparam apb_data_t TIM1_MASK = 32'h3FFF_FFFF;
	localparam apb_data_t TIM3_MASK = 32'h001F_FFFF;    // per bank and all bank refresh
	localparam apb_data_t TCTL_MASK = 32'h0000_0001;    // update_all_timers
	localparam apb_data_t FULL_MASK = '1;

	tim1_word_u tim1_q;
	apb_data_t  tim2_q;    // recovery, turnaround and MR timings
	apb_data_t  tim3_q;
	apb_data_t  dfi_q;     // wrdata, wrlat, rddataen, rdlat
	apb_data_t  pprt_q;
	apb_data_t  tctl_q;

	// replace the strobed bytes of a word, keeping reserved bits clear
	function automatic apb_data_t merge_word
	(
		input apb_data_t old_w,
		input apb_data_t new_w,
		input apb_strb_t strb,
		input apb_data_t mask
	);
		apb_data_t res;
		res = old_w;
		for (int i = 0; i < $bits(apb_strb_t); i++)
		begin
			if (strb[i])
				res[8*i +: 8] = new_w[8*i +: 8] & mask[8*i +: 8];
		end
		return res;
	endfunction

	always_ff @(posedge pclk_i or negedge prst_ni)
	begin
		if (!prst_ni)
		begin
			tim1_q <= '0;
			tim2_q <= '0;
			tim3_q <= '0;
			dfi_q  <= '0;
			pprt_q <= '0;
			tctl_q <= '0;
		end
		else if (acc.wr_en)
		begin
			case (acc.sel)
				REG_TIM1:
				begin
					for (int i = 0; i < $bits(apb_strb_t); i++)
					begin
						if (acc.strb[i])
							tim1_q.bytes[i] <= acc.wdata[8*i +: 8] & TIM1_MASK[8*i +: 8];
					end
				end
				REG_TIM2: tim2_q <= merge_word(tim2_q, acc.wdata, acc.strb, FULL_MASK);
				REG_TIM3: tim3_q <= merge_word(tim3_q, acc.wdata, acc.strb, TIM3_MASK);
				REG_DFI:  dfi_q  <= merge_word(dfi_q, acc.wdata, acc.strb, FULL_MASK);
				REG_PPRT: pprt_q <= merge_word(pprt_q, acc.wdata, acc.strb, FULL_MASK);
				REG_TCTL: tctl_q <= merge_word(tctl_q, acc.wdata, acc.strb, TCTL_MASK);
				default:  ;    // rank registers live in the mode bank
			endcase
		end
	end

	////////////////////////////////////////
	// read word and timer1 fields
	////////////////////////////////////////
	always_comb
	begin
		case (acc.sel)
			REG_TIM1: rdata_o = tim1_q.bytes;
			REG_TIM2: rdata_o = tim2_q;
			REG_TIM3: rdata_o = tim3_q;
			REG_DFI:  rdata_o = dfi_q;
			REG_PPRT: rdata_o = pprt_q;
			REG_TCTL: rdata_o = tctl_q;
			default:  rdata_o = '0;
		endcase
	end

	assign tim1_o = tim1_q.fields;    // same flops, field layout

endmodule

`default_nettype wire

//--- hdl/mode_reg_bank.sv
////////////////////////////////////////
// Rank and PPR registers
////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module mode_reg_bank
(
	input  logic                   pclk_i,
	input  logic                   prst_ni,
	reg_access_if.bank             acc,
	output apb_bus_pkg::apb_data_t rdata_o
);
	import apb_bus_pkg::*;
	import lpddr_reg_pkg::*;

	logic [7:0]  mr_addr;          // mode register number
	logic [7:0]  mr_data;          // MRW payload
	logic        rank_mrw;         // MRW request
	logic        rank_mrr;         // MRR request
	logic [2:0]  rank_index;
	logic        all_rank_mr;      // apply to every rank
	logic        ppr_enable;
	logic [2:0]  ppr_bank_addr;
	logic [15:0] ppr_row_addr;

	logic        wr_mr;
	logic        wr_ppr;
	apb_data_t   mr_word;
	apb_data_t   ppr_word;

	assign wr_mr  = acc.wr_en & (acc.sel == REG_MR);
	assign wr_ppr = acc.wr_en & (acc.sel == REG_PPR);

	always_ff @(posedge pclk_i or negedge prst_ni)
	begin
		if (!prst_ni)
		begin
			mr_addr       <= '0;
			mr_data       <= '0;
			rank_mrw      <= 1'b0;
			rank_mrr      <= 1'b0;
			rank_index    <= '0;
			all_rank_mr   <= 1'b0;
			ppr_enable    <= 1'b0;
			ppr_bank_addr <= '0;
			ppr_row_addr  <= '0;
		end
		else
		begin
			if (wr_mr && acc.strb[0])
				mr_addr <= acc.wdata[7:0];
			if (wr_mr && acc.strb[1])
				mr_data <= acc.wdata[15:8];
			if (wr_mr && acc.strb[2])
				{rank_mrr, rank_mrw} <= acc.wdata[17:16];    // status bits above stay zero
			if (wr_mr && acc.strb[3])
				{all_rank_mr, rank_index} <= {acc.wdata[31], acc.wdata[26:24]};

			if (wr_ppr && acc.strb[0])
				ppr_enable <= acc.wdata[0];
			if (wr_ppr && acc.strb[1])
				ppr_bank_addr <= acc.wdata[10:8];
			if (wr_ppr && acc.strb[2])
				ppr_row_addr[7:0] <= acc.wdata[23:16];
			if (wr_ppr && acc.strb[3])
				ppr_row_addr[15:8] <= acc.wdata[31:24];
		end
	end

	////////////////////////////////////////
	// read words
	////////////////////////////////////////
	assign mr_word  = {all_rank_mr, 4'b0, rank_index, 6'b0, rank_mrr, rank_mrw, mr_data, mr_addr};
	assign ppr_word = {ppr_row_addr, 5'b0, ppr_bank_addr, 7'b0, ppr_enable};    // bit 1 status

	always_comb
	begin
		case (acc.sel)
			REG_MR:  rdata_o = mr_word;
			REG_PPR: rdata_o = ppr_word;
			default: rdata_o = '0;
		endcase
	end

endmodule

`default_nettype wire

//--- hdl/apb_access_decode.sv
////////////////////////////////////////
// APB access decode
////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

`include "lpddr_regs_config.svh"

module apb_access_decode
(
	input  apb_bus_pkg::apb_addr_t paddr_i,
	input  logic                   psel_i,
	input  logic                   penable_i,
	input  logic                   pwrite_i,
	input  apb_bus_pkg::apb_data_t pwdata_i,
	input  apb_bus_pkg::apb_strb_t pstrb_i,
	output logic                   pready_o,
	output logic                   pslverr_o,
	reg_access_if.decoder          acc
);
	import apb_bus_pkg::*;
	import lpddr_reg_pkg::*;

	apb_addr_t word_addr;

	////////////////////////////////////////
	// APB levels
	////////////////////////////////////////
	assign pready_o  = psel_i;    // no wait states
	assign pslverr_o = 1'b0;      // every access completes

	assign acc.wr_en = psel_i & penable_i & pwrite_i;    // access phase of a write
	assign acc.rd_en = psel_i & ~pwrite_i;               // setup and access phase of a read

	assign acc.strb  = pstrb_i;
	assign acc.wdata = pwdata_i;

	////////////////////////////////////////
	// register select
	////////////////////////////////////////
	assign word_addr = {paddr_i[`LPDDR_APB_AW-1:2], 2'b00};    // byte offset ignored

	always_comb
	begin
		case (word_addr)
			`LPDDR_OFS_MR:   acc.sel = REG_MR;
			`LPDDR_OFS_PPR:  acc.sel = REG_PPR;
			`LPDDR_OFS_TIM1: acc.sel = REG_TIM1;
			`LPDDR_OFS_TIM2: acc.sel = REG_TIM2;
			`LPDDR_OFS_TIM3: acc.sel = REG_TIM3;
			`LPDDR_OFS_DFI:  acc.sel = REG_DFI;
			`LPDDR_OFS_PPRT: acc.sel = REG_PPRT;
			`LPDDR_OFS_TCTL: acc.sel = REG_TCTL;
			default:         acc.sel = REG_NONE;    // reads zero, writes dropped
		endcase
	end

endmodule

`default_nettype wire

//--- hdl/reg_access_if.sv
////////////////////////////////////////
// Decoded register access
////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

interface reg_access_if;
	import apb_bus_pkg::*;
	import lpddr_reg_pkg::*;

	logic      wr_en;    // select, enable and write all high
	logic      rd_en;    // select high with write low
	reg_sel_e  sel;      // target register of the word address
	apb_strb_t strb;
	apb_data_t wdata;

	// driven by the APB decoder
	modport decoder
	(
		output wr_en,
		output rd_en,
		output sel,
		output strb,
		output wdata
	);

	// seen by the register banks and the read path
	modport bank
	(
		input wr_en,
		input rd_en,
		input sel,
		input strb,
		input wdata
	);

endinterface

`default_nettype wire

//--- hdl/lpddr_reg_pkg.sv
////////////////////////////////////////
// LPDDR register map types
////////////////////////////////////////
`default_nettype none

`include "lpddr_regs_config.svh"

package lpddr_reg_pkg;

	// register targeted by the current access
	typedef enum logic [3:0]
	{
		REG_NONE,    // unmapped address
		REG_MR,
		REG_PPR,
		REG_TIM1,
		REG_TIM2,
		REG_TIM3,
		REG_DFI,
		REG_PPRT,
		REG_TCTL
	} reg_sel_e;

	////////////////////////////////////////
	// timer1 word
	////////////////////////////////////////
	typedef struct packed
	{
		logic [1:0] rsvd;          // bits 31:30
		logic [5:0] pre_ab2any;    // bits 29:24
		logic [5:0] pre_pb2any;    // bits 23:18
		logic [5:0] act2rw;        // bits 17:12
		logic [4:0] rd2pre;        // bits 11:7
		logic [6:0] act2pre;       // bits 6:0
	} tim1_fields_t;

	typedef logic [`LPDDR_APB_SW-1:0][7:0] tim1_bytes_t;

	// bus writes land per byte, the controller reads fields
	typedef union packed
	{
		tim1_bytes_t  bytes;
		tim1_fields_t fields;
	} tim1_word_u;

endpackage

`default_nettype wire

//--- hdl/apb_bus_pkg.sv
////////////////////////////////////////
// APB bus types
////////////////////////////////////////
`default_nettype none

`include "lpddr_regs_config.svh"

package apb_bus_pkg;

	typedef logic [`LPDDR_APB_AW-1:0] apb_addr_t;    // byte address, low two bits unused
	typedef logic [`LPDDR_APB_DW-1:0] apb_data_t;    // read and write word

	// byte lane enables for writes
	typedef logic [`LPDDR_APB_SW-1:0] apb_strb_t;

endpackage

`default_nettype wire

//--- include/lpddr_regs_config.svh
////////////////////////////////////////
// LPDDR APB register configuration
////////////////////////////////////////
`ifndef LPDDR_REGS_CONFIG_SVH
`define LPDDR_REGS_CONFIG_SVH

// APB bus widths
`define LPDDR_APB_AW 16                   // byte address
`define LPDDR_APB_DW 32                   // data word
`define LPDDR_APB_SW (`LPDDR_APB_DW/8)    // one strobe per byte lane

// word-aligned register offsets
`define LPDDR_OFS_MR   16'h0000           // mode register access and rank control
`define LPDDR_OFS_PPR  16'h0004           // post package repair control
`define LPDDR_OFS_TIM1 16'h0030
`define LPDDR_OFS_TIM2 16'h0034
`define LPDDR_OFS_TIM3 16'h0038
`define LPDDR_OFS_DFI  16'h004C           // DFI phy timing
`define LPDDR_OFS_PPRT 16'h0050           // PPR program time
`define LPDDR_OFS_TCTL 16'h005C           // timer control

`endif
